/* common/epu_pkg.sv */
package epu_pkg;

  // Datapath and bus widths
  localparam int DATA_W   = 32;
  localparam int ADR_W    = 16;
  localparam int REGION_W = 4;
  localparam int MODE_W   = 2;
  localparam int COUNT_W  = 8;

  // Address bits 15:12 select the region
  localparam logic [REGION_W-1:0] REGION_INBUF  = 4'd0;
  localparam logic [REGION_W-1:0] REGION_OUTBUF = 4'd1;
  localparam logic [REGION_W-1:0] REGION_WEIGHT = 4'd2;
  localparam logic [REGION_W-1:0] REGION_CTRL   = 4'd3;

  // Engine modes, code 3 falls back to scale
  localparam logic [MODE_W-1:0] MODE_SCALE = 2'd0;
  localparam logic [MODE_W-1:0] MODE_ACCUM = 2'd1;
  localparam logic [MODE_W-1:0] MODE_RELU  = 2'd2;

  // Control word as the host writes it
  typedef struct packed {
    logic [15:0]        rsvd_hi;
    logic [COUNT_W-1:0] count;
    logic [3:0]         rsvd_lo;
    logic               clear_done;
    logic [MODE_W-1:0]  mode;
    logic               start;
  } ctrl_view_t;

  // Status word as the host reads it
  typedef struct packed {
    logic [15:0]        rsvd_hi;
    logic [COUNT_W-1:0] count;
    logic [3:0]         rsvd_lo;
    logic [MODE_W-1:0]  mode;
    logic               done;
    logic               busy;
  } status_view_t;

  // Same register address, decoded differently for writes and reads
  typedef union packed {
    logic [DATA_W-1:0] raw;
    ctrl_view_t        ctrl;
    status_view_t      status;
  } ctrl_status_u;

endpackage

/* buffer/epu_buffer_bank.sv */
`timescale 1ns/100ps

module epu_buffer_bank #(
  parameter int  DEPTH = 64,
  localparam int AW    = $clog2(DEPTH),
  localparam int SEL_W = epu_pkg::DATA_W / 8
) (
  input  logic                       clk,
  // Host port, byte-enabled writes
  input  logic                       host_en_i,
  input  logic                       host_we_i,
  input  logic [SEL_W-1:0]           host_be_i,
  input  logic [AW-1:0]              host_addr_i,
  input  logic [epu_pkg::DATA_W-1:0] host_wdata_i,
  output logic [epu_pkg::DATA_W-1:0] host_rdata_o,
  // Engine port, full-word access
  input  logic                       eng_en_i,
  input  logic                       eng_we_i,
  input  logic [AW-1:0]              eng_addr_i,
  input  logic [epu_pkg::DATA_W-1:0] eng_wdata_i,
  output logic [epu_pkg::DATA_W-1:0] eng_rdata_o
);

  logic [epu_pkg::DATA_W-1:0] mem [DEPTH];

  always_ff @(posedge clk) begin
    if (host_en_i) begin
      if (host_we_i) begin
        for (int b = 0; b < SEL_W; b++) begin
          if (host_be_i[b]) mem[host_addr_i][8*b +: 8] <= host_wdata_i[8*b +: 8];
        end
      end
      // Old data on a same-cycle write
      host_rdata_o <= mem[host_addr_i];
    end
    if (eng_en_i) begin
      if (eng_we_i) begin
        mem[eng_addr_i] <= eng_wdata_i;
      end else begin
        eng_rdata_o <= mem[eng_addr_i];
      end
    end
  end

endmodule

/* conv/epu_conv_engine.sv */
`timescale 1ns/100ps

module epu_conv_engine #(
  parameter int  DEPTH = 64,
  localparam int AW    = $clog2(DEPTH)
) (
  input  logic                        clk,
  input  logic                        rst,
  // Command from the slave
  input  logic                        start_i,
  input  logic [epu_pkg::MODE_W-1:0]  mode_i,
  input  logic [epu_pkg::COUNT_W-1:0] count_i,
  input  logic [epu_pkg::DATA_W-1:0]  weight_i,
  output logic                        busy_o,
  output logic                        finish_o,
  // Input bank engine port
  output logic                        rd_en_o,
  output logic [AW-1:0]               rd_addr_o,
  input  logic [epu_pkg::DATA_W-1:0]  rd_data_i,
  // Output bank engine port
  output logic                        wr_en_o,
  output logic [AW-1:0]               wr_addr_o,
  output logic [epu_pkg::DATA_W-1:0]  wr_data_o
);

  logic                               busy_q;
  logic                               zero_fin_q;
  logic                               launch;
  logic [epu_pkg::MODE_W-1:0]         mode_q;
  logic [epu_pkg::COUNT_W-1:0]        cnt_q;
  logic [epu_pkg::COUNT_W-1:0]        idx_q;
  logic [epu_pkg::DATA_W-1:0]         weight_q;
  logic [epu_pkg::DATA_W-1:0]         acc_q;

  // Stage 1 waits on read data, stage 2 holds the result
  logic                               s1_vld_q;
  logic                               s1_last_q;
  logic [AW-1:0]                      s1_addr_q;
  logic                               s2_vld_q;
  logic                               s2_last_q;
  logic [AW-1:0]                      s2_addr_q;
  logic [epu_pkg::DATA_W-1:0]         s2_data_q;

  logic                               issue;
  logic                               issue_last;
  logic signed [2*epu_pkg::DATA_W-1:0] prod_full;
  logic [epu_pkg::DATA_W-1:0]         prod;
  logic [epu_pkg::DATA_W-1:0]         sum;
  logic [epu_pkg::DATA_W-1:0]         result;

  assign launch     = start_i && !busy_q;
  assign issue      = busy_q && (idx_q != cnt_q);
  assign issue_last = issue && (idx_q == cnt_q - 1'b1);

  // Signed multiply, low word kept
  assign prod_full = $signed(rd_data_i) * $signed(weight_q);
  assign prod      = prod_full[epu_pkg::DATA_W-1:0];
  assign sum       = acc_q + prod;

  always_comb begin
    case (mode_q)
      epu_pkg::MODE_ACCUM: result = sum;
      epu_pkg::MODE_RELU:  result = prod[epu_pkg::DATA_W-1] ? '0 : prod;
      default:             result = prod;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      busy_q     <= 1'b0;
      zero_fin_q <= 1'b0;
      idx_q      <= '0;
      acc_q      <= '0;
      s1_vld_q   <= 1'b0;
      s2_vld_q   <= 1'b0;
    end else begin
      // Empty run finishes right away
      zero_fin_q <= launch && (count_i == '0);
      s1_vld_q   <= issue;
      s2_vld_q   <= s1_vld_q;
      if (launch) begin
        busy_q <= (count_i != '0);
        idx_q  <= '0;
        acc_q  <= '0;
      end else begin
        if (issue) idx_q <= idx_q + 1'b1;
        if (s1_vld_q) acc_q <= sum;
        if (finish_o) busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (launch) begin
      mode_q   <= mode_i;
      cnt_q    <= count_i;
      weight_q <= weight_i;
    end
    s1_addr_q <= idx_q[AW-1:0];
    s1_last_q <= issue_last;
    s2_addr_q <= s1_addr_q;
    s2_last_q <= s1_last_q;
    s2_data_q <= result;
  end

  assign rd_en_o   = issue;
  assign rd_addr_o = idx_q[AW-1:0];
  assign wr_en_o   = s2_vld_q;
  assign wr_addr_o = s2_addr_q;
  assign wr_data_o = s2_data_q;

  // Finish rides along with the last write
  assign finish_o = (s2_vld_q && s2_last_q) || zero_fin_q;
  assign busy_o   = busy_q;

endmodule

/* source/epu_wb_slave.sv */
`timescale 1ns/100ps

module epu_wb_slave #(
  parameter int  DEPTH = 64,
  localparam int AW    = $clog2(DEPTH),
  localparam int SEL_W = epu_pkg::DATA_W / 8
) (
  input  logic                         clk,
  input  logic                         rst,
  // Wishbone classic slave
  input  logic                         cyc_i,
  input  logic                         stb_i,
  input  logic                         we_i,
  input  logic [epu_pkg::ADR_W-1:0]    adr_i,
  input  logic [epu_pkg::DATA_W-1:0]   dat_i,
  input  logic [SEL_W-1:0]             sel_i,
  output logic [epu_pkg::DATA_W-1:0]   dat_o,
  output logic                         ack_o,
  output logic                         irq_o,
  // Buffer host ports
  input  logic [epu_pkg::DATA_W-1:0]   inbuf_rdata_i,
  input  logic [epu_pkg::DATA_W-1:0]   outbuf_rdata_i,
  output logic                         inbuf_en_o,
  output logic                         inbuf_we_o,
  output logic [SEL_W-1:0]             inbuf_be_o,
  output logic                         outbuf_en_o,
  output logic [AW-1:0]                buf_addr_o,
  output logic [epu_pkg::DATA_W-1:0]   buf_wdata_o,
  // Engine command
  input  logic                         busy_i,
  input  logic                         finish_i,
  output logic                         start_o,
  output logic [epu_pkg::MODE_W-1:0]   mode_o,
  output logic [epu_pkg::COUNT_W-1:0]  count_o,
  output logic [epu_pkg::DATA_W-1:0]   weight_o
);

  typedef enum logic {
    S_IDLE,
    S_ACCESS
  } state_t;

  state_t                          st_q;
  logic                            ack_q;
  logic                            start_q;
  logic                            done_q;
  logic [epu_pkg::MODE_W-1:0]      mode_q;
  logic [epu_pkg::COUNT_W-1:0]     count_q;
  logic [epu_pkg::DATA_W-1:0]      weight_q;

  // Captured request
  logic                            req_we_q;
  logic [epu_pkg::REGION_W-1:0]    req_region_q;
  logic [AW-1:0]                   req_addr_q;
  logic [epu_pkg::DATA_W-1:0]      req_dat_q;
  logic [SEL_W-1:0]                req_sel_q;

  logic                            req_take;
  logic                            access;
  logic                            eng_busy;
  logic                            hit_inbuf;
  logic                            hit_outbuf;
  logic                            hit_weight;
  logic                            hit_ctrl;
  logic                            ctrl_wr;
  epu_pkg::ctrl_status_u           wr_word;
  epu_pkg::ctrl_status_u           status_word;

  // New request only when idle and the previous ack has gone
  assign req_take = (st_q == S_IDLE) && cyc_i && stb_i && !ack_q;
  assign access   = (st_q == S_ACCESS);

  // Start is in flight before the engine reports busy
  assign eng_busy = busy_i | start_q;

  assign hit_inbuf  = access && (req_region_q == epu_pkg::REGION_INBUF);
  assign hit_outbuf = access && (req_region_q == epu_pkg::REGION_OUTBUF);
  assign hit_weight = access && (req_region_q == epu_pkg::REGION_WEIGHT);
  assign hit_ctrl   = access && (req_region_q == epu_pkg::REGION_CTRL);

  assign wr_word.raw = req_dat_q;
  assign ctrl_wr     = hit_ctrl && req_we_q && !eng_busy;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      st_q    <= S_IDLE;
      ack_q   <= 1'b0;
      start_q <= 1'b0;
      done_q  <= 1'b0;
      mode_q  <= '0;
      count_q <= '0;
    end else begin
      ack_q   <= access;
      start_q <= ctrl_wr && wr_word.ctrl.start;
      case (st_q)
        S_IDLE:   if (req_take) st_q <= S_ACCESS;
        default:  st_q <= S_IDLE;
      endcase
      if (ctrl_wr && wr_word.ctrl.start) begin
        mode_q  <= wr_word.ctrl.mode;
        count_q <= wr_word.ctrl.count;
      end
      // Sticky done, set by the engine
      if (finish_i) begin
        done_q <= 1'b1;
      end else if (ctrl_wr && (wr_word.ctrl.clear_done || wr_word.ctrl.start)) begin
        done_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_take) begin
      req_we_q     <= we_i;
      req_region_q <= adr_i[epu_pkg::ADR_W-1 -: epu_pkg::REGION_W];
      req_addr_q   <= adr_i[AW+1:2];
      req_dat_q    <= dat_i;
      req_sel_q    <= sel_i;
    end
    // Byte merge into the weight
    if (hit_weight && req_we_q) begin
      for (int b = 0; b < SEL_W; b++) begin
        if (req_sel_q[b]) weight_q[8*b +: 8] <= req_dat_q[8*b +: 8];
      end
    end
  end

  always_comb begin
    status_word             = '0;
    status_word.status.busy  = eng_busy;
    status_word.status.done  = done_q;
    status_word.status.mode  = mode_q;
    status_word.status.count = count_q;
  end

  // Read mux, sampled by the master during ack
  always_comb begin
    case (req_region_q)
      epu_pkg::REGION_INBUF:  dat_o = inbuf_rdata_i;
      epu_pkg::REGION_OUTBUF: dat_o = outbuf_rdata_i;
      epu_pkg::REGION_WEIGHT: dat_o = weight_q;
      epu_pkg::REGION_CTRL:   dat_o = status_word.raw;
      default:                dat_o = '0;
    endcase
  end

  // Input writes are dropped while the engine runs
  assign inbuf_en_o  = hit_inbuf && (!req_we_q || !eng_busy);
  assign inbuf_we_o  = hit_inbuf && req_we_q && !eng_busy;
  assign inbuf_be_o  = req_sel_q;
  assign outbuf_en_o = hit_outbuf && !req_we_q;
  assign buf_addr_o  = req_addr_q;
  assign buf_wdata_o = req_dat_q;

  assign ack_o    = ack_q;
  assign irq_o    = done_q;
  assign start_o  = start_q;
  assign mode_o   = mode_q;
  assign count_o  = count_q;
  assign weight_o = weight_q;

endmodule

/* source/epu_top.sv */
`timescale 1ns/100ps

module epu_top #(
  parameter int  DEPTH = 64,
  localparam int AW    = $clog2(DEPTH),
  localparam int SEL_W = epu_pkg::DATA_W / 8
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       cyc_i,
  input  logic                       stb_i,
  input  logic                       we_i,
  input  logic [epu_pkg::ADR_W-1:0]  adr_i,
  input  logic [epu_pkg::DATA_W-1:0] dat_i,
  input  logic [SEL_W-1:0]           sel_i,
  output logic [epu_pkg::DATA_W-1:0] dat_o,
  output logic                       ack_o,
  output logic                       irq_o
);

  // Host side of the banks
  logic                        inbuf_en;
  logic                        inbuf_we;
  logic [SEL_W-1:0]            inbuf_be;
  logic                        outbuf_en;
  logic [AW-1:0]               buf_addr;
  logic [epu_pkg::DATA_W-1:0]  buf_wdata;
  logic [epu_pkg::DATA_W-1:0]  inbuf_rdata;
  logic [epu_pkg::DATA_W-1:0]  outbuf_rdata;

  // Engine command and status
  logic                        start;
  logic [epu_pkg::MODE_W-1:0]  mode;
  logic [epu_pkg::COUNT_W-1:0] count;
  logic [epu_pkg::DATA_W-1:0]  weight;
  logic                        busy;
  logic                        finish;

  // Engine side of the banks
  logic                        rd_en;
  logic [AW-1:0]               rd_addr;
  logic [epu_pkg::DATA_W-1:0]  rd_data;
  logic                        wr_en;
  logic [AW-1:0]               wr_addr;
  logic [epu_pkg::DATA_W-1:0]  wr_data;

  epu_wb_slave #(
    .DEPTH (DEPTH)
  ) u_slave (
    .clk            (clk),
    .rst            (rst),
    .cyc_i          (cyc_i),
    .stb_i          (stb_i),
    .we_i           (we_i),
    .adr_i          (adr_i),
    .dat_i          (dat_i),
    .sel_i          (sel_i),
    .dat_o          (dat_o),
    .ack_o          (ack_o),
    .irq_o          (irq_o),
    .inbuf_rdata_i  (inbuf_rdata),
    .outbuf_rdata_i (outbuf_rdata),
    .inbuf_en_o     (inbuf_en),
    .inbuf_we_o     (inbuf_we),
    .inbuf_be_o     (inbuf_be),
    .outbuf_en_o    (outbuf_en),
    .buf_addr_o     (buf_addr),
    .buf_wdata_o    (buf_wdata),
    .busy_i         (busy),
    .finish_i       (finish),
    .start_o        (start),
    .mode_o         (mode),
    .count_o        (count),
    .weight_o       (weight)
  );

  // Input bank, engine port read only
  epu_buffer_bank #(
    .DEPTH (DEPTH)
  ) u_inbuf (
    .clk          (clk),
    .host_en_i    (inbuf_en),
    .host_we_i    (inbuf_we),
    .host_be_i    (inbuf_be),
    .host_addr_i  (buf_addr),
    .host_wdata_i (buf_wdata),
    .host_rdata_o (inbuf_rdata),
    .eng_en_i     (rd_en),
    .eng_we_i     (1'b0),
    .eng_addr_i   (rd_addr),
    .eng_wdata_i  ('0),
    .eng_rdata_o  (rd_data)
  );

  // Output bank, host port read only
  epu_buffer_bank #(
    .DEPTH (DEPTH)
  ) u_outbuf (
    .clk          (clk),
    .host_en_i    (outbuf_en),
    .host_we_i    (1'b0),
    .host_be_i    ('0),
    .host_addr_i  (buf_addr),
    .host_wdata_i (buf_wdata),
    .host_rdata_o (outbuf_rdata),
    .eng_en_i     (wr_en),
    .eng_we_i     (wr_en),
    .eng_addr_i   (wr_addr),
    .eng_wdata_i  (wr_data),
    .eng_rdata_o  ()
  );

  epu_conv_engine #(
    .DEPTH (DEPTH)
  ) u_engine (
    .clk       (clk),
    .rst       (rst),
    .start_i   (start),
    .mode_i    (mode),
    .count_i   (count),
    .weight_i  (weight),
    .busy_o    (busy),
    .finish_o  (finish),
    .rd_en_o   (rd_en),
    .rd_addr_o (rd_addr),
    .rd_data_i (rd_data),
    .wr_en_o   (wr_en),
    .wr_addr_o (wr_addr),
    .wr_data_o (wr_data)
  );

endmodule

/* dv/epu_tb_ref.svh */
`ifndef EPU_TB_REF_SVH
`define EPU_TB_REF_SVH

// 32-bit xorshift with shifts 13, 17, 5
function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] y;
  y = x;
  y = y ^ (y << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

// Byte-select merge of a write into an old word
function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                            input logic [31:0] new_word,
                                            input logic [3:0]  be);
  logic [31:0] w;
  w = old_word;
  for (int b = 0; b < 4; b++) begin
    if (be[b]) w[8*b +: 8] = new_word[8*b +: 8];
  end
  return w;
endfunction

// Expected output word for one element
// prev_sum is the accum result of the element before, zero for the first
function automatic logic [31:0] expected_out(input logic [1:0]  mode,
                                             input logic [31:0] in_word,
                                             input logic [31:0] weight,
                                             input logic [31:0] prev_sum);
  logic signed [63:0] full;
  logic [31:0]        prod;
  logic [31:0]        res;
  full = $signed(in_word) * $signed(weight);
  prod = full[31:0];
  case (mode)
    epu_pkg::MODE_ACCUM: res = prev_sum + prod;
    epu_pkg::MODE_RELU:  res = prod[31] ? 32'h0 : prod;
    default:             res = prod;
  endcase
  return res;
endfunction

task automatic check_value(input string       name,
                           input logic [31:0] expected,
                           input logic [31:0] actual);
  if (actual !== expected) begin
    abort_run($sformatf("ERROR %s: expected %08h, actual %08h", name, expected, actual));
  end
endtask

`endif

/* dv/epu_tb.sv */
`timescale 1ns/100ps

module epu_tb;

  localparam int DEPTH      = 64;
  localparam int WB_LIMIT   = 20;
  localparam int POLL_LIMIT = 200;

  localparam logic [15:0] CTRL_ADR   = {epu_pkg::REGION_CTRL, 12'h000};
  localparam logic [15:0] WEIGHT_ADR = {epu_pkg::REGION_WEIGHT, 12'h000};

  logic        clk;
  logic        rst;
  logic        cyc;
  logic        stb;
  logic        we;
  logic [15:0] adr;
  logic [31:0] dat_w;
  logic [3:0]  sel;
  logic [31:0] dat_r;
  logic        ack;
  logic        irq;

  // Testbench copy of the buffers and the weight
  logic [31:0] rng;
  logic [31:0] in_model [DEPTH];
  logic [31:0] out_model [DEPTH];
  logic [31:0] weight_model;

  epu_top #(
    .DEPTH (DEPTH)
  ) u_epu_top (
    .clk   (clk),
    .rst   (rst),
    .cyc_i (cyc),
    .stb_i (stb),
    .we_i  (we),
    .adr_i (adr),
    .dat_i (dat_w),
    .sel_i (sel),
    .dat_o (dat_r),
    .ack_o (ack),
    .irq_o (irq)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Testbench failed");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  `include "epu_tb_ref.svh"

  function automatic logic [15:0] word_adr(input logic [3:0] region, input int idx);
    return {region, 12'(idx * 4)};
  endfunction

  function automatic logic [31:0] ctrl_word(input logic [1:0] mode, input logic [7:0] count,
                                            input logic start, input logic clear_done);
    epu_pkg::ctrl_status_u cw;
    cw.raw             = '0;
    cw.ctrl.start      = start;
    cw.ctrl.mode       = mode;
    cw.ctrl.clear_done = clear_done;
    cw.ctrl.count      = count;
    return cw.raw;
  endfunction

  // One Wishbone classic transfer, request held until ack
  task automatic bus_cycle(input logic write, input logic [15:0] addr, input logic [31:0] wdata,
                           input logic [3:0] be, output logic [31:0] rdata);
    int waited;
    @(posedge clk);
    cyc   <= 1'b1;
    stb   <= 1'b1;
    we    <= write;
    adr   <= addr;
    dat_w <= wdata;
    sel   <= be;
    waited = 0;
    @(posedge clk);
    while (!ack) begin
      if (waited == WB_LIMIT) begin
        abort_run($sformatf("No acknowledge for the access to address %04h", addr));
      end
      waited++;
      @(posedge clk);
    end
    rdata = dat_r;
    cyc <= 1'b0;
    stb <= 1'b0;
    we  <= 1'b0;
  endtask

  task automatic write_word(input logic [15:0] addr, input logic [31:0] data,
                            input logic [3:0] be);
    logic [31:0] unused;
    bus_cycle(1'b1, addr, data, be, unused);
  endtask

  task automatic read_word(input logic [15:0] addr, output logic [31:0] data);
    bus_cycle(1'b0, addr, 32'h0, 4'hf, data);
  endtask

  task automatic load_weight(input logic [31:0] w);
    weight_model = w;
    write_word(WEIGHT_ADR, w, 4'hf);
  endtask

  // Small signed values with even indices negative, so ReLU sees negative products
  task automatic fill_inputs(input logic small_signed);
    logic [31:0] v;
    for (int i = 0; i < DEPTH; i++) begin
      rng = xorshift32(rng);
      v = rng;
      if (small_signed) begin
        v = {20'd0, rng[11:1], 1'b1};
        if (i % 2 == 0) v = -v;
      end
      in_model[i] = v;
      write_word(word_adr(epu_pkg::REGION_INBUF, i), v, 4'hf);
    end
  endtask

  task automatic wait_done(output epu_pkg::ctrl_status_u st);
    int          polls;
    logic [31:0] rd;
    polls  = 0;
    st.raw = '0;
    while (!st.status.done) begin
      if (polls == POLL_LIMIT) abort_run("The engine did not report done in time");
      read_word(CTRL_ADR, rd);
      st.raw = rd;
      polls++;
    end
  endtask

  task automatic build_expected(input logic [1:0] mode, input int count);
    logic [31:0] sum;
    sum = '0;
    for (int i = 0; i < count; i++) begin
      out_model[i] = expected_out(mode, in_model[i], weight_model, sum);
      if (mode == epu_pkg::MODE_ACCUM) sum = out_model[i];
    end
  endtask

  task automatic check_outputs(input int count, input string name);
    logic [31:0] rd;
    for (int i = 0; i < count; i++) begin
      read_word(word_adr(epu_pkg::REGION_OUTBUF, i), rd);
      check_value($sformatf("%s out[%0d]", name, i), out_model[i], rd);
    end
  endtask

  task automatic check_status(input string name, input epu_pkg::ctrl_status_u st,
                              input logic [1:0] mode, input logic [7:0] count);
    check_value({name, " busy"}, 32'd0, 32'(st.status.busy));
    check_value({name, " done"}, 32'd1, 32'(st.status.done));
    check_value({name, " irq"}, 32'd1, 32'(irq));
    check_value({name, " mode"}, 32'(mode), 32'(st.status.mode));
    check_value({name, " count"}, 32'(count), 32'(st.status.count));
  endtask

  task automatic clear_done(input string name);
    epu_pkg::ctrl_status_u st;
    logic [31:0]           rd;
    write_word(CTRL_ADR, ctrl_word(2'd0, 8'd0, 1'b0, 1'b1), 4'hf);
    read_word(CTRL_ADR, rd);
    st.raw = rd;
    check_value({name, " done cleared"}, 32'd0, 32'(st.status.done));
    check_value({name, " irq cleared"}, 32'd0, 32'(irq));
  endtask

  task automatic check_readback();
    logic [31:0] rd;
    logic [31:0] data;
    logic [3:0]  be;
    int          idx;
    for (int i = 0; i < DEPTH; i++) begin
      rng = xorshift32(rng);
      in_model[i] = rng;
      write_word(word_adr(epu_pkg::REGION_INBUF, i), rng, 4'hf);
    end
    // Partial writes over known contents
    repeat (16) begin
      rng  = xorshift32(rng);
      idx  = int'(rng % DEPTH);
      be   = rng[7:4];
      rng  = xorshift32(rng);
      data = rng;
      in_model[idx] = merge_bytes(in_model[idx], data, be);
      write_word(word_adr(epu_pkg::REGION_INBUF, idx), data, be);
    end
    for (int i = 0; i < DEPTH; i++) begin
      read_word(word_adr(epu_pkg::REGION_INBUF, i), rd);
      check_value($sformatf("input readback [%0d]", i), in_model[i], rd);
    end
    rng = xorshift32(rng);
    load_weight(rng);
    rng = xorshift32(rng);
    weight_model = merge_bytes(weight_model, rng, 4'b0110);
    write_word(WEIGHT_ADR, rng, 4'b0110);
    read_word(WEIGHT_ADR, rd);
    check_value("weight readback", weight_model, rd);
  endtask

  task automatic run_mode(input logic [1:0] mode, input string name);
    epu_pkg::ctrl_status_u st;
    logic [7:0]            count;
    logic                  relu;
    relu = (mode == epu_pkg::MODE_RELU);
    fill_inputs(relu);
    rng = xorshift32(rng);
    load_weight(relu ? {24'd0, rng[7:1], 1'b1} : rng);
    rng   = xorshift32(rng);
    count = 8'(rng % DEPTH + 1);
    write_word(CTRL_ADR, ctrl_word(mode, count, 1'b1, 1'b0), 4'hf);
    wait_done(st);
    build_expected(mode, int'(count));
    check_outputs(int'(count), name);
    check_status(name, st, mode, count);
    clear_done(name);
  endtask

  // Control and input writes land while the long run is busy
  task automatic check_busy_writes();
    epu_pkg::ctrl_status_u st;
    logic [31:0]           rd;
    fill_inputs(1'b0);
    rng = xorshift32(rng);
    load_weight(rng);
    write_word(CTRL_ADR, ctrl_word(epu_pkg::MODE_ACCUM, 8'(DEPTH), 1'b1, 1'b0), 4'hf);
    write_word(CTRL_ADR, ctrl_word(epu_pkg::MODE_RELU, 8'd3, 1'b1, 1'b1), 4'hf);
    write_word(word_adr(epu_pkg::REGION_INBUF, DEPTH - 1), ~in_model[DEPTH - 1], 4'hf);
    read_word(CTRL_ADR, rd);
    st.raw = rd;
    check_value("busy flag", 32'd1, 32'(st.status.busy));
    wait_done(st);
    build_expected(epu_pkg::MODE_ACCUM, DEPTH);
    check_outputs(DEPTH, "busy run");
    check_status("busy run", st, epu_pkg::MODE_ACCUM, 8'(DEPTH));
    read_word(word_adr(epu_pkg::REGION_INBUF, DEPTH - 1), rd);
    check_value("busy input write", in_model[DEPTH - 1], rd);
    clear_done("busy run");
  endtask

  task automatic check_empty_run();
    epu_pkg::ctrl_status_u st;
    rng = xorshift32(rng);
    load_weight(rng);
    write_word(CTRL_ADR, ctrl_word(epu_pkg::MODE_SCALE, 8'd0, 1'b1, 1'b0), 4'hf);
    wait_done(st);
    check_status("empty run", st, epu_pkg::MODE_SCALE, 8'd0);
    check_outputs(DEPTH, "empty run");
  endtask

  task automatic check_unmapped();
    logic [31:0] rd;
    logic [3:0]  region;
    for (int r = 4; r < 16; r += 5) begin
      region = 4'(r);
      rng = xorshift32(rng);
      write_word({region, 12'h010}, rng, 4'hf);
      read_word({region, 12'h010}, rd);
      check_value($sformatf("unmapped region %0d", r), 32'd0, rd);
    end
    read_word(WEIGHT_ADR, rd);
    check_value("weight after unmapped writes", weight_model, rd);
  endtask

  initial begin
    logic [31:0] rd;
    rng   = 32'h0c763371;
    rst   = 1'b1;
    cyc   = 1'b0;
    stb   = 1'b0;
    we    = 1'b0;
    adr   = '0;
    dat_w = '0;
    sel   = '0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    // Idle state after reset
    read_word(CTRL_ADR, rd);
    check_value("reset status", 32'd0, rd);
    check_value("reset irq", 32'd0, 32'(irq));

    check_readback();
    run_mode(epu_pkg::MODE_SCALE, "scale");
    run_mode(epu_pkg::MODE_ACCUM, "accum");
    run_mode(epu_pkg::MODE_RELU, "relu");
    check_busy_writes();
    check_empty_run();
    check_unmapped();

    $display("Testbench passed");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+dv
common/epu_pkg.sv
buffer/epu_buffer_bank.sv
conv/epu_conv_engine.sv
source/epu_wb_slave.sv
source/epu_top.sv
dv/epu_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the EPU testbench with Verilator and run it
# The exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=epu_tb_sim

verilator --binary --timing -Wno-fatal \
  --top-module epu_tb \
  -f verilog.f \
  --Mdir "$BUILD_DIR" \
  -o "$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

"./$BUILD_DIR/$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

echo "Simulation finished"
exit 0
